/* common/csr_pkg.sv */
`default_nettype none

package csr_pkg;

    // Basic data widths
    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;
    typedef logic [11:0] csr_addr_t;

    // Only user and machine privilege exist
    typedef enum logic [1:0] {
        PRIV_USER    = 2'b00,
        PRIV_MACHINE = 2'b11
    } priv_t;

    // Command from the execute stage
    typedef enum logic [2:0] {
        CSR_X     = 3'd0,
        CSR_W     = 3'd1,
        CSR_S     = 3'd2,
        CSR_C     = 3'd3,
        CSR_ECALL = 3'd4,
        CSR_MRET  = 3'd5
    } csr_cmd_t;

    // Machine trap setup
    localparam csr_addr_t CSR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_MISA     = 12'h301;
    localparam csr_addr_t CSR_MIE      = 12'h304;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;

    // Machine trap handling
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;
    localparam csr_addr_t CSR_MIP      = 12'h344;

    // Machine information, read-only space
    localparam csr_addr_t CSR_MHARTID  = 12'hf14;

    // User counters, read-only space
    localparam csr_addr_t CSR_CYCLE    = 12'hc00;
    localparam csr_addr_t CSR_TIME     = 12'hc01;
    localparam csr_addr_t CSR_CYCLEH   = 12'hc80;
    localparam csr_addr_t CSR_TIMEH    = 12'hc81;

    // Machine counters, same source as cycle
    localparam csr_addr_t CSR_MCYCLE   = 12'hb00;
    localparam csr_addr_t CSR_MCYCLEH  = 12'hb80;

    // Exception causes
    localparam word_t CAUSE_ECALL_U     = 32'd8;
    localparam word_t CAUSE_ECALL_M     = 32'd11;
    // Interrupt bit plus code 7
    localparam word_t CAUSE_M_TIMER_IRQ = 32'h8000_0007;

    // Field positions
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LSB  = 11;
    // MTIP in mip sits at the same position
    localparam int MIE_MTIE_BIT     = 7;

    // MXL = 1 for RV32, extensions M, I and A
    localparam word_t MISA_VALUE = 32'h4000_1101;

endpackage

`default_nettype wire

/* hdl/csr_cmd_decode.sv */
`default_nettype none

module csr_cmd_decode
    import csr_pkg::*;
(
    input  wire       valid,
    input  wire csr_cmd_t  csr_cmd,
    input  wire csr_addr_t csr_addr,
    input  wire word_t     op1_data,
    input  wire word_t     cur_value,
    input  wire priv_t     mode,
    input  wire       irq_take,
    output logic      rd_ok,
    output logic      wr_en,
    output word_t     wdata
);

    logic can_access;
    logic read_only;
    logic is_rw_cmd;

    // Address bits 9:8 hold the lowest privilege allowed
    assign can_access = (csr_addr[9:8] <= mode);

    // Top two bits both set marks the read-only space
    assign read_only = &csr_addr[11:10];

    assign is_rw_cmd = (csr_cmd == CSR_W) ||
                       (csr_cmd == CSR_S) ||
                       (csr_cmd == CSR_C);

    // Reads only need the privilege check
    assign rd_ok = can_access;

    // No write when the cycle is taken by an interrupt
    assign wr_en = valid && !irq_take && is_rw_cmd && can_access && !read_only;

    // New value from old value and operand
    always_comb begin
        case (csr_cmd)
            CSR_W:   wdata = op1_data;
            CSR_S:   wdata = cur_value | op1_data;
            CSR_C:   wdata = cur_value & ~op1_data;
            default: wdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* csr_file/csr_regfile.sv */
`default_nettype none

module csr_regfile
    import csr_pkg::*;
#(
    parameter word_t HART_ID = '0
) (
    input  wire       clk,
    input  wire       rst,
    input  wire       valid,
    input  wire csr_addr_t csr_addr,
    input  wire       rd_ok,
    input  wire       wr_en,
    input  wire word_t     wdata,
    input  wire priv_t     mode,
    input  wire       mtip,
    input  wire       trap_enter,
    input  wire word_t     trap_cause,
    input  wire word_t     pc,
    input  wire       trap_return,
    input  wire dword_t    cycle,
    input  wire dword_t    time_count,
    output word_t     cur_value,
    output word_t     rdata,
    output logic      mstatus_mie,
    output priv_t     mstatus_mpp,
    output logic      mie_mtie,
    output word_t     mtvec,
    output word_t     mepc
);

    // Stored fields not visible at the ports
    logic  mstatus_mpie;
    word_t mscratch;
    word_t mcause;

    // Packed views for the read mux
    word_t mstatus_value;
    word_t mie_value;
    word_t mip_value;

    always_comb begin
        mstatus_value = '0;
        mstatus_value[MSTATUS_MIE_BIT]      = mstatus_mie;
        mstatus_value[MSTATUS_MPIE_BIT]     = mstatus_mpie;
        mstatus_value[MSTATUS_MPP_LSB +: 2] = mstatus_mpp;
    end

    always_comb begin
        mie_value = '0;
        mie_value[MIE_MTIE_BIT] = mie_mtie;
        // MTIP shares the MTIE position
        mip_value = '0;
        mip_value[MIE_MTIE_BIT] = mtip;
    end

    // Old value, also fed to the decoder for set and clear
    always_comb begin
        case (csr_addr)
            CSR_MSTATUS:  cur_value = mstatus_value;
            CSR_MISA:     cur_value = MISA_VALUE;
            CSR_MIE:      cur_value = mie_value;
            CSR_MTVEC:    cur_value = mtvec;
            CSR_MSCRATCH: cur_value = mscratch;
            CSR_MEPC:     cur_value = mepc;
            CSR_MCAUSE:   cur_value = mcause;
            CSR_MIP:      cur_value = mip_value;
            CSR_MHARTID:  cur_value = HART_ID;
            // Counters come from outside the stage
            CSR_CYCLE:    cur_value = cycle[31:0];
            CSR_CYCLEH:   cur_value = cycle[63:32];
            CSR_MCYCLE:   cur_value = cycle[31:0];
            CSR_MCYCLEH:  cur_value = cycle[63:32];
            CSR_TIME:     cur_value = time_count[31:0];
            CSR_TIMEH:    cur_value = time_count[63:32];
            default:      cur_value = '0;
        endcase
    end

    // Read result, one cycle after the instruction
    always_ff @(posedge clk) begin
        if (rst) begin
            rdata <= '0;
        end else if (valid) begin
            rdata <= rd_ok ? cur_value : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_mpp  <= PRIV_MACHINE;
            mie_mtie     <= 1'b0;
            mtvec        <= '0;
            mscratch     <= '0;
            mepc         <= '0;
            mcause       <= '0;
        end else begin
            // Software writes, masked to the implemented fields
            if (wr_en) begin
                case (csr_addr)
                    CSR_MSTATUS: begin
                        mstatus_mie  <= wdata[MSTATUS_MIE_BIT];
                        mstatus_mpie <= wdata[MSTATUS_MPIE_BIT];
                        // Only U and M are legal, anything else maps to U
                        if (wdata[MSTATUS_MPP_LSB +: 2] == PRIV_MACHINE) begin
                            mstatus_mpp <= PRIV_MACHINE;
                        end else begin
                            mstatus_mpp <= PRIV_USER;
                        end
                    end
                    CSR_MIE:      mie_mtie <= wdata[MIE_MTIE_BIT];
                    CSR_MTVEC:    mtvec    <= wdata;
                    CSR_MSCRATCH: mscratch <= wdata;
                    // Instructions are word aligned
                    CSR_MEPC:     mepc     <= {wdata[31:2], 2'b00};
                    CSR_MCAUSE:   mcause   <= wdata;
                    // misa, mip, mhartid and counters ignore writes
                    default: begin
                    end
                endcase
            end

            // Trap side updates win over the software write
            if (trap_enter) begin
                mepc         <= pc;
                mcause       <= trap_cause;
                mstatus_mpp  <= mode;
                mstatus_mpie <= mstatus_mie;
                mstatus_mie  <= 1'b0;
            end else if (trap_return) begin
                mstatus_mie  <= mstatus_mpie;
                mstatus_mpie <= 1'b1;
                // Lowest supported mode after mret
                mstatus_mpp  <= PRIV_USER;
            end
        end
    end

endmodule

`default_nettype wire

/* trap/csr_trap_ctrl.sv */
`default_nettype none

module csr_trap_ctrl
    import csr_pkg::*;
(
    input  wire       clk,
    input  wire       rst,
    input  wire       valid,
    input  wire csr_cmd_t  csr_cmd,
    input  wire word_t     pc,
    input  wire dword_t    inst_id,
    input  wire       mem_write,
    input  wire dword_t    mtime,
    input  wire dword_t    mtimecmp,
    input  wire       mstatus_mie,
    input  wire priv_t     mstatus_mpp,
    input  wire       mie_mtie,
    input  wire word_t     mtvec,
    input  wire word_t     mepc,
    output priv_t     mode,
    output logic      mtip,
    output logic      irq_take,
    output logic      trap_enter,
    output word_t     trap_cause,
    output logic      trap_return,
    output logic      stall,
    output logic      trap,
    output word_t     trap_vector
);

    // Id and pc of the instruction seen last cycle
    dword_t saved_id;
    word_t  saved_pc;

    logic  new_inst;
    logic  is_ecall;
    logic  is_mret;
    logic  is_rw_cmd;
    word_t mtvec_base;
    word_t irq_target;

    // Timer interrupt only on a stage without a memory write
    assign irq_take = valid && mtip && mstatus_mie && mie_mtie && !mem_write;

    // Interrupt has priority over ecall and mret
    assign is_ecall = valid && !irq_take && (csr_cmd == CSR_ECALL);
    assign is_mret  = valid && !irq_take && (csr_cmd == CSR_MRET);

    assign trap_enter  = irq_take || is_ecall;
    assign trap_return = is_mret;
    assign trap        = irq_take || is_ecall || is_mret;

    // Cause follows the mode the ecall came from
    always_comb begin
        if (irq_take) begin
            trap_cause = CAUSE_M_TIMER_IRQ;
        end else if (mode == PRIV_USER) begin
            trap_cause = CAUSE_ECALL_U;
        end else begin
            trap_cause = CAUSE_ECALL_M;
        end
    end

    // First cycle of a fresh instruction
    assign new_inst  = (inst_id != saved_id) || (pc != saved_pc);
    assign is_rw_cmd = (csr_cmd == CSR_W) || (csr_cmd == CSR_S) || (csr_cmd == CSR_C);
    assign stall     = valid && (is_rw_cmd || irq_take) && new_inst;

    // mtvec mode 01 is vectored, base plus four times the code
    assign mtvec_base = {mtvec[31:2], 2'b00};
    assign irq_target = (mtvec[1:0] == 2'b01) ?
                        mtvec_base + {CAUSE_M_TIMER_IRQ[29:0], 2'b00} : mtvec_base;

    always_ff @(posedge clk) begin
        if (rst) begin
            saved_id <= '0;
            saved_pc <= '0;
        end else begin
            saved_id <= inst_id;
            saved_pc <= pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mode        <= PRIV_MACHINE;
            mtip        <= 1'b0;
            trap_vector <= '0;
        end else begin
            // Pending bit frozen while an interrupt is taken
            if (valid && !irq_take) begin
                mtip <= (mtime >= mtimecmp);
            end

            if (irq_take) begin
                mode        <= PRIV_MACHINE;
                trap_vector <= irq_target;
            end else if (is_ecall) begin
                // Exceptions always use the base address
                mode        <= PRIV_MACHINE;
                trap_vector <= mtvec_base;
            end else if (is_mret) begin
                mode        <= mstatus_mpp;
                trap_vector <= mepc;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/csr_stage.sv */
`default_nettype none

module csr_stage
    import csr_pkg::*;
#(
    parameter word_t HART_ID = '0
) (
    input  wire       clk,
    input  wire       rst,
    input  wire       valid,
    input  wire word_t     pc,
    input  wire dword_t    inst_id,
    input  wire csr_cmd_t  csr_cmd,
    input  wire csr_addr_t csr_addr,
    input  wire word_t     op1_data,
    input  wire       mem_write,
    input  wire dword_t    cycle,
    input  wire dword_t    time_count,
    input  wire dword_t    mtime,
    input  wire dword_t    mtimecmp,
    output word_t     rdata,
    output logic      stall,
    output logic      trap,
    output word_t     trap_vector
);

    // Decoder to register file
    logic  rd_ok;
    logic  wr_en;
    word_t wdata;
    word_t cur_value;

    // Trap controller state
    priv_t mode;
    logic  mtip;
    logic  irq_take;
    logic  trap_enter;
    word_t trap_cause;
    logic  trap_return;

    // Register file fields needed by the trap logic
    logic  mstatus_mie;
    priv_t mstatus_mpp;
    logic  mie_mtie;
    word_t mtvec;
    word_t mepc;

    csr_cmd_decode u_decode (
        .valid     (valid),
        .csr_cmd   (csr_cmd),
        .csr_addr  (csr_addr),
        .op1_data  (op1_data),
        .cur_value (cur_value),
        .mode      (mode),
        .irq_take  (irq_take),
        .rd_ok     (rd_ok),
        .wr_en     (wr_en),
        .wdata     (wdata)
    );

    csr_regfile #(
        .HART_ID (HART_ID)
    ) u_regfile (
        .clk         (clk),
        .rst         (rst),
        .valid       (valid),
        .csr_addr    (csr_addr),
        .rd_ok       (rd_ok),
        .wr_en       (wr_en),
        .wdata       (wdata),
        .mode        (mode),
        .mtip        (mtip),
        .trap_enter  (trap_enter),
        .trap_cause  (trap_cause),
        .pc          (pc),
        .trap_return (trap_return),
        .cycle       (cycle),
        .time_count  (time_count),
        .cur_value   (cur_value),
        .rdata       (rdata),
        .mstatus_mie (mstatus_mie),
        .mstatus_mpp (mstatus_mpp),
        .mie_mtie    (mie_mtie),
        .mtvec       (mtvec),
        .mepc        (mepc)
    );

    csr_trap_ctrl u_trap (
        .clk         (clk),
        .rst         (rst),
        .valid       (valid),
        .csr_cmd     (csr_cmd),
        .pc          (pc),
        .inst_id     (inst_id),
        .mem_write   (mem_write),
        .mtime       (mtime),
        .mtimecmp    (mtimecmp),
        .mstatus_mie (mstatus_mie),
        .mstatus_mpp (mstatus_mpp),
        .mie_mtie    (mie_mtie),
        .mtvec       (mtvec),
        .mepc        (mepc),
        .mode        (mode),
        .mtip        (mtip),
        .irq_take    (irq_take),
        .trap_enter  (trap_enter),
        .trap_cause  (trap_cause),
        .trap_return (trap_return),
        .stall       (stall),
        .trap        (trap),
        .trap_vector (trap_vector)
    );

endmodule

`default_nettype wire

/* bench/csr_checker.sv */
`default_nettype none

module csr_checker
    import csr_pkg::*;
(
    input  wire            clk,
    input  wire            rst,
    input  wire            valid,
    input  wire csr_cmd_t  csr_cmd,
    input  wire            stall,
    input  wire            trap,
    input  wire word_t     rdata,
    input  wire word_t     trap_vector,
    input  wire word_t     exp_rdata,
    input  wire            exp_trap,
    input  wire word_t     exp_vector,
    input  wire [7:0]      test_code,
    input  wire [31:0]     inst_no,
    output int             mismatches
);

    // Results still due one cycle after retirement
    logic       pend;
    word_t      pend_rdata;
    logic       pend_trap;
    word_t      pend_vector;
    logic [7:0] pend_code;
    int         pend_line;

    // State of the instruction in flight
    int         stall_cycles;
    logic       trap_held;
    logic       reset_checked;

    function automatic string test_name(input logic [7:0] code);
        case (code)
            8'h00:   return "reset";
            8'h01:   return "csr_rw";
            8'h02:   return "access_check";
            8'h03:   return "ecall_machine";
            8'h04:   return "mret_user";
            8'h05:   return "timer_irq";
            default: return "unknown";
        endcase
    endfunction

    // CSR accesses and taken interrupts hold the stage once
    function automatic int expected_stalls(input csr_cmd_t cmd, input logic with_trap);
        if (cmd == CSR_W || cmd == CSR_S || cmd == CSR_C) begin
            return 1;
        end
        if (with_trap && cmd != CSR_ECALL && cmd != CSR_MRET) begin
            return 1;
        end
        return 0;
    endfunction

    task automatic report_mismatch(input string field, input word_t expected,
                                   input word_t actual, input logic [7:0] code,
                                   input int line);
        $display("Mismatch in %s, trace line %0d: %s expected %h, actual %h",
                 test_name(code), line, field, expected, actual);
        mismatches = mismatches + 1;
    endtask

    // Mid-cycle sampling, inputs and outputs are settled here
    always @(negedge clk) begin
        logic trap_seen;
        int   want;
        if (rst) begin
            mismatches    = 0;
            pend          = 1'b0;
            stall_cycles  = 0;
            trap_held     = 1'b0;
            reset_checked = 1'b0;
        end else begin
            // Outputs right after reset
            if (!reset_checked) begin
                reset_checked = 1'b1;
                if (rdata !== '0) report_mismatch("rdata", '0, rdata, 8'h00, 0);
                if (trap_vector !== '0) report_mismatch("trap_vector", '0, trap_vector, 8'h00, 0);
                if (stall !== 1'b0) report_mismatch("stall", '0, {31'b0, stall}, 8'h00, 0);
                if (trap !== 1'b0) report_mismatch("trap", '0, {31'b0, trap}, 8'h00, 0);
            end

            // Registered results of the previous instruction
            if (pend) begin
                pend = 1'b0;
                if (rdata !== pend_rdata) begin
                    report_mismatch("rdata", pend_rdata, rdata, pend_code, pend_line);
                end
                if (pend_trap && trap_vector !== pend_vector) begin
                    report_mismatch("trap_vector", pend_vector, trap_vector, pend_code,
                                    pend_line);
                end
            end

            if (valid && stall) begin
                stall_cycles = stall_cycles + 1;
                // An interrupt shows trap in its stall cycle
                trap_held    = trap_held | trap;
            end else if (valid) begin
                trap_seen = trap_held | trap;
                want      = expected_stalls(csr_cmd, exp_trap);
                if (trap_seen !== exp_trap) begin
                    report_mismatch("trap", {31'b0, exp_trap}, {31'b0, trap_seen},
                                    test_code, inst_no);
                end
                if (stall_cycles != want) begin
                    $display("Mismatch in %s, trace line %0d: stall cycles expected %0d, actual %0d",
                             test_name(test_code), inst_no, want, stall_cycles);
                    mismatches = mismatches + 1;
                end
                pend         = 1'b1;
                pend_rdata   = exp_rdata;
                pend_trap    = exp_trap;
                pend_vector  = exp_vector;
                pend_code    = test_code;
                pend_line    = inst_no;
                stall_cycles = 0;
                trap_held    = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* bench/tb_csr_stage.sv */
`default_nettype none

module tb_csr_stage
    import csr_pkg::*;
;

    localparam word_t  HART_ID      = 32'h0000_0005;
    // Counter values seen by cycle, time and their high halves
    localparam dword_t CYCLE_VALUE  = 64'h0000_0012_3456_789a;
    localparam dword_t TIME_VALUE   = 64'h0000_00ab_cdef_0123;
    localparam int     RESET_CYCLES = 16;
    // Longest stall accepted for one instruction
    localparam int     HOLD_LIMIT   = 4;
    // Idle cycles so the last read result reaches the checker
    localparam int     DRAIN_CYCLES = 3;

    logic      clk;
    logic      rst;
    logic      valid;
    word_t     pc;
    dword_t    inst_id;
    csr_cmd_t  csr_cmd;
    csr_addr_t csr_addr;
    word_t     op1_data;
    logic      mem_write;
    dword_t    cycle;
    dword_t    time_count;
    dword_t    mtime;
    dword_t    mtimecmp;
    word_t     rdata;
    logic      stall;
    logic      trap;
    word_t     trap_vector;

    // Expected values, driven together with the instruction
    word_t      exp_rdata;
    logic       exp_trap;
    word_t      exp_vector;
    logic [7:0] test_code;
    int         inst_no;

    int   mismatches;
    int   timeouts;
    int   trace_errors;
    logic abort;

    csr_stage #(
        .HART_ID (HART_ID)
    ) dut (
        .clk         (clk),
        .rst         (rst),
        .valid       (valid),
        .pc          (pc),
        .inst_id     (inst_id),
        .csr_cmd     (csr_cmd),
        .csr_addr    (csr_addr),
        .op1_data    (op1_data),
        .mem_write   (mem_write),
        .cycle       (cycle),
        .time_count  (time_count),
        .mtime       (mtime),
        .mtimecmp    (mtimecmp),
        .rdata       (rdata),
        .stall       (stall),
        .trap        (trap),
        .trap_vector (trap_vector)
    );

    csr_checker u_check (
        .clk         (clk),
        .rst         (rst),
        .valid       (valid),
        .csr_cmd     (csr_cmd),
        .stall       (stall),
        .trap        (trap),
        .rdata       (rdata),
        .trap_vector (trap_vector),
        .exp_rdata   (exp_rdata),
        .exp_trap    (exp_trap),
        .exp_vector  (exp_vector),
        .test_code   (test_code),
        .inst_no     (inst_no),
        .mismatches  (mismatches)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // Stage empty, no instruction presented
    task automatic drive_idle();
        valid      = 1'b0;
        pc         = '0;
        inst_id    = '0;
        csr_cmd    = CSR_X;
        csr_addr   = '0;
        op1_data   = '0;
        mem_write  = 1'b0;
        mtime      = '0;
        mtimecmp   = '0;
        exp_rdata  = '0;
        exp_trap   = 1'b0;
        exp_vector = '0;
        test_code  = '0;
    endtask

    // Entered right after a rising edge, returns on the retiring edge
    task automatic apply_instruction(
        input logic [7:0] f_cmd,
        input csr_addr_t  f_addr,
        input word_t      f_op1,
        input word_t      f_pc,
        input dword_t     f_id,
        input logic       f_mw,
        input dword_t     f_mtime,
        input dword_t     f_cmp,
        input word_t      f_rdata,
        input logic       f_trap,
        input word_t      f_vector,
        input logic [7:0] f_code
    );
        int held;
        held = 0;
        #2;
        valid      = 1'b1;
        csr_cmd    = csr_cmd_t'(f_cmd[2:0]);
        csr_addr   = f_addr;
        op1_data   = f_op1;
        pc         = f_pc;
        inst_id    = f_id;
        mem_write  = f_mw;
        mtime      = f_mtime;
        mtimecmp   = f_cmp;
        exp_rdata  = f_rdata;
        exp_trap   = f_trap;
        exp_vector = f_vector;
        test_code  = f_code;
        inst_no    = inst_no + 1;
        // Hold the instruction while the stage stalls
        @(negedge clk);
        while (stall && held < HOLD_LIMIT) begin
            held = held + 1;
            @(negedge clk);
        end
        if (stall) begin
            $display("Timeout: stall stayed high for more than %0d cycles at trace line %0d",
                     HOLD_LIMIT, inst_no);
            timeouts = timeouts + 1;
            abort    = 1'b1;
        end
        @(posedge clk);
    endtask

    initial begin
        int          fd;
        int          n;
        string       line;
        logic [7:0]  f_cmd;
        logic [11:0] f_addr;
        logic [31:0] f_op1;
        logic [31:0] f_pc;
        logic [63:0] f_id;
        logic [7:0]  f_mw;
        logic [63:0] f_mtime;
        logic [63:0] f_cmp;
        logic [31:0] f_rdata;
        logic [7:0]  f_trap;
        logic [31:0] f_vector;
        logic [7:0]  f_code;

        timeouts     = 0;
        trace_errors = 0;
        abort        = 1'b0;
        inst_no      = 0;
        rst          = 1'b1;
        cycle        = CYCLE_VALUE;
        time_count   = TIME_VALUE;
        drive_idle();

        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
        @(posedge clk);

        fd = $fopen("bench/csr_trace.txt", "r");
        if (fd == 0) begin
            $display("Error: the trace file bench/csr_trace.txt could not be opened");
            trace_errors = trace_errors + 1;
        end else begin
            while (!abort && $fgets(line, fd) != 0) begin
                // Lines starting with a hash are column notes
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                                f_cmd, f_addr, f_op1, f_pc, f_id, f_mw, f_mtime, f_cmp,
                                f_rdata, f_trap, f_vector, f_code);
                    if (n == 12) begin
                        apply_instruction(f_cmd, f_addr, f_op1, f_pc, f_id, f_mw[0],
                                          f_mtime, f_cmp, f_rdata, f_trap[0], f_vector,
                                          f_code);
                    end else begin
                        $display("Error: a trace line has %0d fields instead of 12", n);
                        trace_errors = trace_errors + 1;
                    end
                end
            end
            $fclose(fd);
        end
        if (inst_no == 0) begin
            $display("Error: no instruction was read from the trace file");
            trace_errors = trace_errors + 1;
        end

        #2;
        drive_idle();
        repeat (DRAIN_CYCLES) @(posedge clk);

        $display("Error counts: %0d mismatches, %0d timeouts, %0d trace errors",
                 mismatches, timeouts, trace_errors);
        if (mismatches == 0 && timeouts == 0 && trace_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/csr_trace.txt */
# cmd addr op1 pc id mem_write mtime mtimecmp exp_rdata exp_trap exp_vector test, all hex
# cmd 0 none, 1 write, 2 set, 3 clear, 4 ecall, 5 mret; exp_vector checked only with exp_trap
1 340 a5a50f0f 00000100 01 0 0 100 a5a50f0f 0 0 1
0 340 00000000 00000104 02 0 0 100 a5a50f0f 0 0 1
2 340 0000f0f0 00000108 03 0 0 100 a5a5ffff 0 0 1
0 340 00000000 0000010c 04 0 0 100 a5a5ffff 0 0 1
3 340 ff0000ff 00000110 05 0 0 100 00a5ff00 0 0 1
0 340 00000000 00000114 06 0 0 100 00a5ff00 0 0 1
0 f14 00000000 00000118 07 0 0 100 00000005 0 0 2
1 301 00000000 0000011c 08 0 0 100 40001101 0 0 2
0 c00 00000000 00000120 09 0 0 100 3456789a 0 0 2
0 c80 00000000 00000124 0a 0 0 100 00000012 0 0 2
0 c01 00000000 00000128 0b 0 0 100 cdef0123 0 0 2
0 c81 00000000 0000012c 0c 0 0 100 000000ab 0 0 2
1 c00 ffffffff 00000130 0d 0 0 100 3456789a 0 0 2
1 305 00000200 00000134 0e 0 0 100 00000200 0 0 3
4 000 00000000 00001000 0f 0 0 100 00000000 1 00000200 3
0 342 00000000 00001004 10 0 0 100 0000000b 0 0 3
0 341 00000000 00001008 11 0 0 100 00001000 0 0 3
0 300 00000000 0000100c 12 0 0 100 00001800 0 0 3
3 300 00001800 00001010 13 0 0 100 00000000 0 0 4
1 341 00002003 00001014 14 0 0 100 00002000 0 0 4
5 000 00000000 00001018 15 0 0 100 00000000 1 00002000 4
0 340 00000000 00002000 16 0 0 100 00000000 0 0 4
1 340 12345678 00002004 17 0 0 100 00000000 0 0 2
0 c00 00000000 00002008 18 0 0 100 3456789a 0 0 2
4 000 00000000 0000200c 19 0 0 100 00000000 1 00000200 4
0 342 00000000 00001100 1a 0 0 100 00000008 0 0 4
0 341 00000000 00001104 1b 0 0 100 0000200c 0 0 4
0 340 00000000 00001108 1c 0 0 100 00a5ff00 0 0 2
0 300 00000000 0000110c 1d 0 0 100 00000000 0 0 4
1 305 00000301 00001110 1e 0 0 100 00000301 0 0 5
1 304 00000080 00001114 1f 0 0 100 00000080 0 0 5
2 300 00000008 00001118 20 0 0 100 00000008 0 0 5
0 344 00000000 0000111c 21 0 200 100 00000000 0 0 5
0 340 00000000 00001120 22 1 200 100 00a5ff00 0 0 5
0 340 00000000 00003000 23 0 200 100 00a5ff00 1 0000031c 5
0 342 00000000 00003004 24 0 200 100 80000007 0 0 5
0 341 00000000 00003008 25 0 200 100 00003000 0 0 5
0 344 00000000 0000300c 26 0 200 100 00000080 0 0 5
0 300 00000000 00003010 27 0 200 100 00001880 0 0 5

/* sim.f */
common/csr_pkg.sv
hdl/csr_cmd_decode.sv
csr_file/csr_regfile.sv
trap/csr_trap_ctrl.sv
hdl/csr_stage.sv
bench/csr_checker.sv
bench/tb_csr_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the CSR stage testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module tb_csr_stage \
    -Mdir obj_dir -o tb_csr_stage

./obj_dir/tb_csr_stage | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi

echo "Simulation finished without failures"
